//--- design/axim_store_pkg.sv
package axim_store_pkg;

   localparam int addr_w      = 32;
   localparam int data_w      = 32;
   localparam int strb_w      = data_w / 8;
   localparam int lite_addr_w = 4;

   // One 64-byte block of 4-byte words per burst
   localparam int burst_len   = 16;
   localparam int burst_bytes = burst_len * strb_w;  // Address step between bursts
   localparam int len_w       = 8;

   localparam int fifo_depth_cmd  = 4;
   localparam int fifo_depth_data = 32;

   // AXI-lite register map
   localparam logic [lite_addr_w-1:0] reg_ctrl   = 'h0;  // Bit 0 starts a transfer
   localparam logic [lite_addr_w-1:0] reg_base   = 'h4;
   localparam logic [lite_addr_w-1:0] reg_size   = 'h8;  // Words
   localparam logic [lite_addr_w-1:0] reg_status = 'hC;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [len_w-1:0]  len;   // Beats minus one
   } burst_cmd_t;

endpackage

//--- design/xfer_ctrl_if.sv
`timescale 1ns/100ps

interface xfer_ctrl_if import axim_store_pkg::*; ();

   logic              start;  // One-cycle pulse
   logic [addr_w-1:0] base;
   logic [data_w-1:0] size;   // Words
   logic              busy;
   logic              done;   // Sticky until the next start

   modport regs (
      output start, base, size,
      input  busy, done
   );

   modport planner (
      input  start, base, size,
      output busy, done
   );

endinterface

//--- design/ctrl_axil_regs.sv
`timescale 1ns/100ps

module ctrl_axil_regs import axim_store_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic [lite_addr_w-1:0] s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,
   input  logic [data_w-1:0]      s_axi_wdata_i,
   input  logic [strb_w-1:0]      s_axi_wstrb_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,
   output logic [1:0]             s_axi_bresp_o,
   output logic                   s_axi_bvalid_o,
   input  logic                   s_axi_bready_i,
   input  logic [lite_addr_w-1:0] s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,
   output logic [data_w-1:0]      s_axi_rdata_o,
   output logic [1:0]             s_axi_rresp_o,
   output logic                   s_axi_rvalid_o,
   input  logic                   s_axi_rready_i,
   xfer_ctrl_if.regs              ctrl
);

   logic              wr_accept;
   logic              wr_fire;
   logic              rd_fire;
   logic [addr_w-1:0] base_q;
   logic [data_w-1:0] size_q;
   logic [data_w-1:0] status;

   // Address and data are taken together, one write at a time
   assign wr_accept = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_awready_o && !s_axi_bvalid_o;
   assign wr_fire   = s_axi_awready_o && s_axi_awvalid_i;
   assign rd_fire   = s_axi_arready_o && s_axi_arvalid_i;

   assign status        = {{(data_w-2){1'b0}}, ctrl.done, ctrl.busy};
   assign s_axi_bresp_o = 2'b00;  // OKAY
   assign s_axi_rresp_o = 2'b00;
   assign ctrl.base     = base_q;
   assign ctrl.size     = size_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         s_axi_awready_o <= 1'b0;
         s_axi_wready_o  <= 1'b0;
         s_axi_bvalid_o  <= 1'b0;
         ctrl.start      <= 1'b0;
      end else begin
         s_axi_awready_o <= wr_accept;
         s_axi_wready_o  <= wr_accept;
         if (wr_fire) begin
            s_axi_bvalid_o <= 1'b1;
         end else if (s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
         end
         ctrl.start <= wr_fire && (s_axi_awaddr_i == reg_ctrl) && s_axi_wstrb_i[0] &&
                       s_axi_wdata_i[0];
      end
   end

   // Byte lanes of base and size
   always_ff @(posedge clk) begin
      if (reset_i) begin
         base_q <= '0;
         size_q <= '0;
      end else if (wr_fire) begin
         for (int b = 0; b < strb_w; b++) begin
            if (s_axi_wstrb_i[b] && s_axi_awaddr_i == reg_base) begin
               base_q[8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
            end
            if (s_axi_wstrb_i[b] && s_axi_awaddr_i == reg_size) begin
               size_q[8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         s_axi_arready_o <= 1'b0;
         s_axi_rvalid_o  <= 1'b0;
      end else begin
         s_axi_arready_o <= s_axi_arvalid_i && !s_axi_arready_o && !s_axi_rvalid_o;
         if (rd_fire) begin
            s_axi_rvalid_o <= 1'b1;
         end else if (s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         case (s_axi_araddr_i)
            reg_base:   s_axi_rdata_o <= base_q;
            reg_size:   s_axi_rdata_o <= size_q;
            reg_status: s_axi_rdata_o <= status;
            default:    s_axi_rdata_o <= '0;  // Control is write-only
         endcase
      end
   end

endmodule

//--- design/burst_planner.sv
`timescale 1ns/100ps

module burst_planner import axim_store_pkg::*; (
   input  logic         clk,
   input  logic         reset_i,
   xfer_ctrl_if.planner ctrl,
   output burst_cmd_t   cmd_o,
   output logic         cmd_valid_o,
   input  logic         cmd_ready_i,
   input  logic         burst_done_i
);

   logic [addr_w-1:0] addr_q;
   logic [data_w-1:0] remain_q;     // Words not yet covered by a command
   logic [data_w-1:0] beats;
   logic [data_w-1:0] issued_q;
   logic [data_w-1:0] completed_q;
   logic              launch;
   logic              cmd_fire;
   logic              last_done;

   assign launch      = ctrl.start && !ctrl.busy;
   assign beats       = (remain_q > data_w'(burst_len)) ? data_w'(burst_len) : remain_q;
   assign cmd_valid_o = ctrl.busy && (remain_q != '0);
   assign cmd_fire    = cmd_valid_o && cmd_ready_i;
   assign cmd_o.addr  = addr_q;
   assign cmd_o.len   = beats[len_w-1:0] - 1'b1;

   // B response of the final burst, all commands already issued
   assign last_done = burst_done_i && (remain_q == '0) && (completed_q + 1'b1 == issued_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ctrl.busy   <= 1'b0;
         ctrl.done   <= 1'b0;
         remain_q    <= '0;
         issued_q    <= '0;
         completed_q <= '0;
      end else if (launch) begin
         ctrl.busy   <= (ctrl.size != '0);
         ctrl.done   <= (ctrl.size == '0);  // Empty transfer ends at once
         remain_q    <= ctrl.size;
         issued_q    <= '0;
         completed_q <= '0;
      end else if (ctrl.busy) begin
         if (cmd_fire) begin
            remain_q <= remain_q - beats;
            issued_q <= issued_q + 1'b1;
         end
         if (burst_done_i) begin
            completed_q <= completed_q + 1'b1;
         end
         if (last_done) begin
            ctrl.busy <= 1'b0;
            ctrl.done <= 1'b1;
         end
      end
   end

   // Running burst address
   always_ff @(posedge clk) begin
      if (launch) begin
         addr_q <= ctrl.base;
      end else if (cmd_fire) begin
         addr_q <= addr_q + addr_w'(burst_bytes);
      end
   end

endmodule

//--- design/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
   parameter type payload_t = logic,
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     reset_i,
   input  payload_t push_data_i,
   input  logic     push_valid_i,
   output logic     push_ready_o,
   output payload_t pop_data_o,
   output logic     pop_valid_o,
   input  logic     pop_ready_i
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   assign push_ready_o = (count != cnt_w'(depth));  // Not full
   assign pop_valid_o  = (count != '0);
   assign pop_data_o   = mem[rd_ptr];
   assign push         = push_valid_i && push_ready_o;
   assign pop          = pop_valid_o && pop_ready_i;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle, or push and pop together
         endcase
      end
   end

endmodule

//--- design/axim_wr_engine.sv
`timescale 1ns/100ps

module axim_wr_engine import axim_store_pkg::*; (
   input  logic              clk,
   input  logic              reset_i,
   input  burst_cmd_t        cmd_i,
   input  logic              cmd_valid_i,
   output logic              cmd_ready_o,
   input  logic [data_w-1:0] data_i,
   input  logic              data_valid_i,
   output logic              data_ready_o,
   output logic [addr_w-1:0] m_axi_awaddr_o,
   output logic [len_w-1:0]  m_axi_awlen_o,
   output logic              m_axi_awvalid_o,
   input  logic              m_axi_awready_i,
   output logic [data_w-1:0] m_axi_wdata_o,
   output logic [strb_w-1:0] m_axi_wstrb_o,
   output logic              m_axi_wlast_o,
   output logic              m_axi_wvalid_o,
   input  logic              m_axi_wready_i,
   input  logic              m_axi_bvalid_i,
   output logic              m_axi_bready_o,
   output logic              burst_done_o
);

   typedef enum logic [1:0] {
      st_addr,
      st_data,
      st_resp
   } state_t;

   state_t           state;
   logic [len_w-1:0] len_q;
   logic [len_w-1:0] beat_q;
   logic             aw_fire;
   logic             w_fire;

   // Command sits at the FIFO head until AW is accepted, then it is popped
   assign m_axi_awvalid_o = (state == st_addr) && cmd_valid_i;
   assign m_axi_awaddr_o  = cmd_i.addr;
   assign m_axi_awlen_o   = cmd_i.len;
   assign aw_fire         = m_axi_awvalid_o && m_axi_awready_i;
   assign cmd_ready_o     = aw_fire;

   assign m_axi_wvalid_o = (state == st_data) && data_valid_i;
   assign m_axi_wdata_o  = data_i;
   assign m_axi_wstrb_o  = '1;
   assign m_axi_wlast_o  = (state == st_data) && (beat_q == len_q);
   assign w_fire         = m_axi_wvalid_o && m_axi_wready_i;
   assign data_ready_o   = (state == st_data) && m_axi_wready_i;

   assign m_axi_bready_o = (state == st_resp);
   assign burst_done_o   = m_axi_bready_o && m_axi_bvalid_i;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state  <= st_addr;
         beat_q <= '0;
      end else begin
         case (state)
            st_addr: begin
               if (aw_fire) begin
                  state  <= st_data;
                  beat_q <= '0;
               end
            end
            st_data: begin
               if (w_fire) begin
                  beat_q <= beat_q + 1'b1;
                  if (m_axi_wlast_o) begin
                     state <= st_resp;
                  end
               end
            end
            st_resp: begin
               if (m_axi_bvalid_i) begin
                  state <= st_addr;
               end
            end
            default: state <= st_addr;
         endcase
      end
   end

   // Length of the burst in the data phase
   always_ff @(posedge clk) begin
      if (aw_fire) begin
         len_q <= cmd_i.len;
      end
   end

endmodule

//--- design/axim_store_top.sv
`timescale 1ns/100ps

module axim_store_top import axim_store_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_i,
   // AXI-lite control slave
   input  logic [lite_addr_w-1:0] s_axi_awaddr_i,
   input  logic                   s_axi_awvalid_i,
   output logic                   s_axi_awready_o,
   input  logic [data_w-1:0]      s_axi_wdata_i,
   input  logic [strb_w-1:0]      s_axi_wstrb_i,
   input  logic                   s_axi_wvalid_i,
   output logic                   s_axi_wready_o,
   output logic [1:0]             s_axi_bresp_o,
   output logic                   s_axi_bvalid_o,
   input  logic                   s_axi_bready_i,
   input  logic [lite_addr_w-1:0] s_axi_araddr_i,
   input  logic                   s_axi_arvalid_i,
   output logic                   s_axi_arready_o,
   output logic [data_w-1:0]      s_axi_rdata_o,
   output logic [1:0]             s_axi_rresp_o,
   output logic                   s_axi_rvalid_o,
   input  logic                   s_axi_rready_i,
   // Store data stream
   input  logic [data_w-1:0]      wr_tdata_i,
   input  logic                   wr_tvalid_i,
   output logic                   wr_tready_o,
   // AXI4 write master
   output logic [addr_w-1:0]      m_axi_awaddr_o,
   output logic [len_w-1:0]       m_axi_awlen_o,
   output logic                   m_axi_awvalid_o,
   input  logic                   m_axi_awready_i,
   output logic [data_w-1:0]      m_axi_wdata_o,
   output logic [strb_w-1:0]      m_axi_wstrb_o,
   output logic                   m_axi_wlast_o,
   output logic                   m_axi_wvalid_o,
   input  logic                   m_axi_wready_i,
   input  logic                   m_axi_bvalid_i,
   output logic                   m_axi_bready_o
);

   burst_cmd_t        plan_cmd;
   logic              plan_cmd_valid;
   logic              plan_cmd_ready;
   burst_cmd_t        eng_cmd;
   logic              eng_cmd_valid;
   logic              eng_cmd_ready;
   logic [data_w-1:0] eng_data;
   logic              eng_data_valid;
   logic              eng_data_ready;
   logic              burst_done;

   xfer_ctrl_if ctrl_if ();

   ctrl_axil_regs ctrl_regs_inst (
      .*,
      .ctrl (ctrl_if.regs)
   );

   burst_planner planner_inst (
      .clk          (clk),
      .reset_i      (reset_i),
      .ctrl         (ctrl_if.planner),
      .cmd_o        (plan_cmd),
      .cmd_valid_o  (plan_cmd_valid),
      .cmd_ready_i  (plan_cmd_ready),
      .burst_done_i (burst_done)
   );

   stream_fifo #(
      .payload_t (burst_cmd_t),
      .depth     (fifo_depth_cmd)
   ) cmd_fifo (
      .clk          (clk),
      .reset_i      (reset_i),
      .push_data_i  (plan_cmd),
      .push_valid_i (plan_cmd_valid),
      .push_ready_o (plan_cmd_ready),
      .pop_data_o   (eng_cmd),
      .pop_valid_o  (eng_cmd_valid),
      .pop_ready_i  (eng_cmd_ready)
   );

   stream_fifo #(
      .payload_t (logic [data_w-1:0]),
      .depth     (fifo_depth_data)
   ) data_fifo (
      .clk          (clk),
      .reset_i      (reset_i),
      .push_data_i  (wr_tdata_i),
      .push_valid_i (wr_tvalid_i),
      .push_ready_o (wr_tready_o),
      .pop_data_o   (eng_data),
      .pop_valid_o  (eng_data_valid),
      .pop_ready_i  (eng_data_ready)
   );

   // AXI master ports connect by name
   axim_wr_engine wr_engine_inst (
      .*,
      .cmd_i        (eng_cmd),
      .cmd_valid_i  (eng_cmd_valid),
      .cmd_ready_o  (eng_cmd_ready),
      .data_i       (eng_data),
      .data_valid_i (eng_data_valid),
      .data_ready_o (eng_data_ready),
      .burst_done_o (burst_done)
   );

endmodule

//--- verif/tb_axim_store.sv
`timescale 1ns/100ps

module tb_axim_store import axim_store_pkg::*; ();

   localparam int n_rand      = 6;  // Random transfers with light stalls
   localparam int n_xfers     = n_rand + 2;
   localparam int max_words   = 70;
   localparam int wd_cycles   = n_xfers * max_words * 20 + 2000;
   localparam int beats_max   = 16;
   localparam int block_bytes = 64;

   logic clk;
   logic reset_i;
   logic [lite_addr_w-1:0] s_axi_awaddr_i, s_axi_araddr_i;
   logic s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
   logic [data_w-1:0] s_axi_wdata_i, s_axi_rdata_o;
   logic [strb_w-1:0] s_axi_wstrb_i;
   logic [1:0] s_axi_bresp_o, s_axi_rresp_o;
   logic s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
   logic s_axi_rvalid_o, s_axi_rready_i;
   logic [data_w-1:0] wr_tdata_i;
   logic wr_tvalid_i, wr_tready_o;
   logic [addr_w-1:0] m_axi_awaddr_o;
   logic [len_w-1:0] m_axi_awlen_o;
   logic m_axi_awvalid_o, m_axi_awready_i;
   logic [data_w-1:0] m_axi_wdata_o;
   logic [strb_w-1:0] m_axi_wstrb_o;
   logic m_axi_wlast_o, m_axi_wvalid_o, m_axi_wready_i, m_axi_bvalid_i, m_axi_bready_o;

   logic [31:0] mem [logic [31:0]];  // Slave memory indexed by the byte address of each word
   logic [31:0] exp_q [$];           // Words accepted by the stream, in order
   logic [31:0] aw_addr_q [$];
   int          aw_len_q [$];
   int          beat;
   int          b_pending;
   logic        b_hs;
   logic        s_hs;
   int          aw_count, beat_count, words_left, stall_pct, gap_pct;
   logic [31:0] cur_base;
   int          cur_size;
   logic        tready_low;
   int          errors, tests, err_mark;
   string       test_name;

   axim_store_top i_axim_store_top (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      repeat (wd_cycles) @(posedge clk);
      $display("Timeout: run still going after %0d cycles", wd_cycles);
      $display("Test failed");
      $finish;
   end

   task automatic report_mismatch(input string what, input logic [31:0] exp, act);
      $display("ERR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      errors++;
   endtask

   task automatic report_fault(input string msg);
      $display("%s: %s", test_name, msg);
      errors++;
   endtask

   // AXI4 slave memory with random ready and response timing
   always begin : axi_slave_model
      int          remain;
      int          exp_len;
      logic [31:0] addr;
      @(negedge clk);
      m_axi_awready_i = ($urandom % 100) >= stall_pct;
      m_axi_wready_i  = ($urandom % 100) >= stall_pct;
      if (!(m_axi_bvalid_i && !b_hs)) begin  // A raised response holds until taken
         m_axi_bvalid_i = (b_pending > 0) && (($urandom % 100) >= stall_pct);
      end
      b_hs = 1'b0;
      #1;
      if (m_axi_awvalid_o && m_axi_awready_i) begin
         remain  = cur_size - beats_max * aw_count;
         exp_len = (remain > beats_max) ? beats_max - 1 : remain - 1;
         if (remain <= 0) begin
            report_fault("AW request beyond the end of the transfer");
         end else begin
            if (m_axi_awaddr_o != cur_base + 32'(aw_count * block_bytes))
               report_mismatch("awaddr", cur_base + 32'(aw_count * block_bytes), m_axi_awaddr_o);
            if (m_axi_awlen_o != exp_len)
               report_mismatch("awlen", exp_len, m_axi_awlen_o);
         end
         aw_addr_q.push_back(m_axi_awaddr_o);
         aw_len_q.push_back(m_axi_awlen_o);
         aw_count++;
      end
      if (m_axi_wvalid_o && m_axi_wready_i) begin
         if (aw_addr_q.size() == 0) begin
            report_fault("W beat without an accepted AW request");
         end else begin
            addr = aw_addr_q[0] + 32'(beat * 4);
            if (mem.exists(addr)) report_fault($sformatf("address 0x%08h written twice", addr));
            mem[addr] = m_axi_wdata_o;
            if (m_axi_wstrb_o != '1) report_mismatch("wstrb", 32'hF, m_axi_wstrb_o);
            if (m_axi_wlast_o != (beat == aw_len_q[0]))
               report_mismatch("wlast", beat == aw_len_q[0], m_axi_wlast_o);
            beat_count++;
            if (beat == aw_len_q[0]) begin
               void'(aw_addr_q.pop_front());
               void'(aw_len_q.pop_front());
               beat = 0;
               b_pending++;
            end else begin
               beat++;
            end
         end
      end
      if (m_axi_bvalid_i && m_axi_bready_o) begin
         b_pending--;
         b_hs = 1'b1;
      end
   end

   // Store stream whose valid holds until the word is taken
   always begin : stream_driver
      @(negedge clk);
      if (!(wr_tvalid_i && !s_hs)) begin
         wr_tvalid_i = (words_left > 0) && (($urandom % 100) >= gap_pct);
         wr_tdata_i  = $urandom;
      end
      s_hs = 1'b0;
      #1;
      if (!wr_tready_o) tready_low = 1'b1;
      if (wr_tvalid_i && wr_tready_o) begin
         exp_q.push_back(wr_tdata_i);
         words_left--;
         s_hs = 1'b1;
      end
   end

   task automatic lite_write(input logic [lite_addr_w-1:0] addr, input logic [31:0] data);
      @(negedge clk);
      s_axi_awaddr_i  = addr;
      s_axi_awvalid_i = 1'b1;
      s_axi_wdata_i   = data;
      s_axi_wvalid_i  = 1'b1;
      s_axi_bready_i  = 1'b1;
      @(negedge clk);
      while (!s_axi_awready_o) @(negedge clk);
      if (!s_axi_wready_o) report_fault("wready not raised together with awready");
      @(negedge clk);  // Write taken on the edge just passed
      s_axi_awvalid_i = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      while (!s_axi_bvalid_o) @(negedge clk);
      if (s_axi_bresp_o != 2'b00) report_mismatch("bresp", 32'h0, s_axi_bresp_o);
      @(negedge clk);
      s_axi_bready_i = 1'b0;
   endtask

   task automatic lite_read(input logic [lite_addr_w-1:0] addr, output logic [31:0] data);
      @(negedge clk);
      s_axi_araddr_i  = addr;
      s_axi_arvalid_i = 1'b1;
      s_axi_rready_i  = 1'b1;
      @(negedge clk);
      while (!s_axi_arready_o) @(negedge clk);
      @(negedge clk);
      s_axi_arvalid_i = 1'b0;
      while (!s_axi_rvalid_o) @(negedge clk);
      data = s_axi_rdata_o;
      if (s_axi_rresp_o != 2'b00) report_mismatch("rresp", 32'h0, s_axi_rresp_o);
      @(negedge clk);
      s_axi_rready_i = 1'b0;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = errors;
   endtask

   task automatic end_test();
      tests++;
      if (errors == err_mark) $display("%s: ok", test_name);
      else $display("%s: %0d error(s)", test_name, errors - err_mark);
   endtask

   // Model state changes on the rising edge, away from the model processes
   task automatic start_transfer(input logic [31:0] base, input int size, input int stall, gap);
      @(posedge clk);
      cur_base   = base;
      cur_size   = size;
      stall_pct  = stall;
      gap_pct    = gap;
      aw_count   = 0;
      beat_count = 0;
      tready_low = 1'b0;
      mem.delete();
      exp_q.delete();
      lite_write(reg_base, base);
      lite_write(reg_size, 32'(size));
      lite_write(reg_ctrl, 32'h1);
   endtask

   task automatic run_transfer(input logic [31:0] base, input int size, input int stall, gap);
      logic [31:0] st;
      int          n_aw;
      logic [31:0] addr;
      start_transfer(base, size, stall, gap);
      lite_read(reg_status, st);  // No stream data yet, so the transfer cannot end
      if (st != 32'h1) report_mismatch("status while busy", 32'h1, st);
      @(posedge clk);
      words_left = size;
      st = '0;
      while (!st[1]) lite_read(reg_status, st);
      if (st != 32'h2) report_mismatch("status at end", 32'h2, st);
      n_aw = (size + beats_max - 1) / beats_max;
      if (aw_count != n_aw) report_mismatch("AW request count", n_aw, aw_count);
      if (beat_count != size) report_mismatch("W beat count", size, beat_count);
      for (int i = 0; i < exp_q.size(); i++) begin
         addr = base + 32'(i * 4);
         if (!mem.exists(addr)) begin
            report_fault($sformatf("no write to address 0x%08h", addr));
         end else if (mem[addr] != exp_q[i]) begin
            report_mismatch($sformatf("word %0d", i), exp_q[i], mem[addr]);
         end
      end
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] base;
      int          size;
      void'($urandom(32));
      {s_axi_awaddr_i, s_axi_awvalid_i, s_axi_wdata_i, s_axi_wvalid_i, s_axi_bready_i} = '0;
      {s_axi_araddr_i, s_axi_arvalid_i, s_axi_rready_i} = '0;
      s_axi_wstrb_i = '1;
      {wr_tdata_i, wr_tvalid_i, m_axi_awready_i, m_axi_wready_i, m_axi_bvalid_i} = '0;
      {beat, b_pending, b_hs, s_hs, aw_count, beat_count, words_left} = '0;
      {errors, tests, err_mark, cur_base, cur_size, tready_low} = '0;
      stall_pct = 30;
      gap_pct   = 30;
      reset_i   = 1'b1;
      repeat (16) @(negedge clk);
      reset_i = 1'b0;

      begin_test("reg_access");
      @(negedge clk);
      if (m_axi_awvalid_o || m_axi_wvalid_o || m_axi_wlast_o || s_axi_bvalid_o ||
          s_axi_rvalid_o || s_axi_awready_o || s_axi_wready_o || s_axi_arready_o ||
          !wr_tready_o) report_fault("outputs not idle after reset");
      base = $urandom & 32'hFFFF_FFFC;
      size = $urandom_range(max_words, 1);
      lite_write(reg_base, base);
      lite_write(reg_size, 32'(size));
      lite_read(reg_base, rd);
      if (rd != base) report_mismatch("base", base, rd);
      lite_read(reg_size, rd);
      if (rd != size) report_mismatch("size", size, rd);
      lite_read(reg_status, rd);
      if (rd != 32'h0) report_mismatch("status", 32'h0, rd);
      end_test();

      for (int t = 0; t < n_rand; t++) begin
         begin_test($sformatf("xfer_%0d", t));
         run_transfer($urandom & 32'h0FFF_FFFC, $urandom_range(max_words, 1), 30, 30);
         end_test();
      end

      begin_test("stall_flow");  // Back-to-back stream words against a slow slave
      run_transfer($urandom & 32'h0FFF_FFFC, $urandom_range(max_words, 48), 85, 0);
      if (!tready_low) report_fault("wr_tready_o never went low under back-pressure");
      end_test();

      begin_test("zero_size");
      start_transfer($urandom & 32'h0FFF_FFFC, 0, 30, 30);
      lite_read(reg_status, rd);
      if (rd != 32'h2) report_mismatch("status", 32'h2, rd);
      repeat (20) @(negedge clk);
      if (aw_count != 0) report_mismatch("AW request count", 0, aw_count);
      end_test();

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- src.f
design/axim_store_pkg.sv
design/xfer_ctrl_if.sv
design/ctrl_axil_regs.sv
design/burst_planner.sv
design/stream_fifo.sv
design/axim_wr_engine.sv
design/axim_store_top.sv
verif/tb_axim_store.sv
